//--- fetch_bypass_pkg.sv
// ***************************************************************************
// Fetch bypass package
// Sizes, vector types and the port state encoding that the uncached
// instruction fetch path shares between its blocks
// ***************************************************************************

`default_nettype none

package fetch_bypass_pkg;

  // Fetch side and refill side sizes
  localparam int unsigned NUM_PORTS      = 2;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned FETCH_WIDTH    = 32;
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned FETCH_ALIGN    = 2;
  localparam int unsigned LINE_ALIGN     = 4;
  localparam int unsigned WORDS_PER_LINE = 4;

  // Refills that may be in flight at once, one order FIFO entry each
  localparam int unsigned ORDER_DEPTH    = 4;

  typedef logic [ADDR_WIDTH-1:0]                 addr_t;
  typedef logic [FETCH_WIDTH-1:0]                fetch_data_t;
  typedef logic [LINE_WIDTH-1:0]                 line_data_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]     word_sel_t;
  typedef logic [NUM_PORTS-1:0]                  port_mask_t;
  typedef logic [$clog2(NUM_PORTS)-1:0]          port_idx_t;

  // Per-port request sequence
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESPONSE,
    PRESENT
  } bypass_state_e;

endpackage

`default_nettype wire

//--- fetch_bypass_port.sv
// ***************************************************************************
// Fetch bypass port
// Runs the request sequence for one fetch port, picks the addressed word
// out of the returned line and presents it for a single cycle
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fetch_bypass_port (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          inst_valid_i,
  input  fetch_bypass_pkg::addr_t       inst_addr_i,

  input  logic                          order_full_i,
  input  logic                          grant_i,
  input  logic                          rsp_valid_i,
  input  fetch_bypass_pkg::line_data_t  rsp_data_i,
  input  logic                          rsp_error_i,

  output logic                          req_o,
  output fetch_bypass_pkg::addr_t       req_addr_o,
  output logic                          inst_ready_o,
  output fetch_bypass_pkg::fetch_data_t inst_data_o,
  output logic                          inst_error_o
);

  fetch_bypass_pkg::bypass_state_e state_q;
  fetch_bypass_pkg::bypass_state_e state_d;
  fetch_bypass_pkg::word_sel_t     word_idx;
  fetch_bypass_pkg::fetch_data_t   rsp_word;
  logic                            load_word;

  // Refills always fetch a whole line, so drop the offset inside the line
  assign req_addr_o = {inst_addr_i[fetch_bypass_pkg::ADDR_WIDTH-1:fetch_bypass_pkg::LINE_ALIGN],
                       {fetch_bypass_pkg::LINE_ALIGN{1'b0}}};

  // Word position of the fetch address inside its line
  assign word_idx = inst_addr_i[fetch_bypass_pkg::LINE_ALIGN-1:fetch_bypass_pkg::FETCH_ALIGN];
  assign rsp_word = rsp_data_i[word_idx*fetch_bypass_pkg::FETCH_WIDTH +:
                               fetch_bypass_pkg::FETCH_WIDTH];

  always_comb begin
    state_d      = state_q;
    req_o        = 1'b0;
    inst_ready_o = 1'b0;
    load_word    = 1'b0;
    unique case (state_q)
      fetch_bypass_pkg::IDLE: begin
        if (inst_valid_i) begin
          state_d = fetch_bypass_pkg::REQUEST;
        end
      end
      fetch_bypass_pkg::REQUEST: begin
        // Only ask for a refill when the order FIFO can still record it
        if (!order_full_i) begin
          req_o = 1'b1;
          if (grant_i) begin
            state_d = fetch_bypass_pkg::WAIT_RESPONSE;
          end
        end
      end
      fetch_bypass_pkg::WAIT_RESPONSE: begin
        if (rsp_valid_i) begin
          load_word = 1'b1;
          state_d   = fetch_bypass_pkg::PRESENT;
        end
      end
      fetch_bypass_pkg::PRESENT: begin
        // The word sits in the output register for exactly this cycle
        inst_ready_o = 1'b1;
        state_d      = fetch_bypass_pkg::IDLE;
      end
      default: begin
        state_d = fetch_bypass_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= fetch_bypass_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Holds the last word and error flag until this port's next response
  always_ff @(posedge clk_i) begin
    if (load_word) begin
      inst_data_o  <= rsp_word;
      inst_error_o <= rsp_error_i;
    end
  end

endmodule

`default_nettype wire

//--- fetch_bypass_arbiter.sv
// ***************************************************************************
// Fetch bypass arbiter
// Round-robin choice among the port requests onto the single refill
// request channel, holding the choice while the channel stalls
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fetch_bypass_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,

  input  fetch_bypass_pkg::port_mask_t                          req_i,
  input  fetch_bypass_pkg::addr_t [fetch_bypass_pkg::NUM_PORTS-1:0] req_addr_i,
  output fetch_bypass_pkg::port_mask_t                          grant_o,

  output logic                                                  refill_req_valid_o,
  input  logic                                                  refill_req_ready_i,
  output fetch_bypass_pkg::addr_t                               refill_req_addr_o
);

  fetch_bypass_pkg::port_idx_t rr_q;
  fetch_bypass_pkg::port_idx_t lock_idx_q;
  logic                        lock_q;
  fetch_bypass_pkg::port_idx_t pick_idx;
  logic                        pick_valid;
  fetch_bypass_pkg::port_idx_t sel_idx;
  logic                        xfer;

  // Search from the pointer upwards for the first requesting port
  always_comb begin
    int unsigned cand;
    pick_idx   = rr_q;
    pick_valid = 1'b0;
    for (int unsigned k = 0; k < fetch_bypass_pkg::NUM_PORTS; k++) begin
      cand = (rr_q + k) % fetch_bypass_pkg::NUM_PORTS;
      if (!pick_valid && req_i[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = fetch_bypass_pkg::port_idx_t'(cand);
      end
    end
  end

  // A stalled request keeps its port so valid and address stay stable
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;

  assign refill_req_valid_o = req_i[sel_idx];
  assign refill_req_addr_o  = req_addr_i[sel_idx];
  assign xfer               = refill_req_valid_o & refill_req_ready_i;

  assign grant_o = xfer ? (fetch_bypass_pkg::port_mask_t'(1) << sel_idx) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= refill_req_valid_o & ~refill_req_ready_i;
      lock_idx_q <= sel_idx;
      // Next search starts just past the port that was served
      if (xfer) begin
        if (sel_idx == fetch_bypass_pkg::port_idx_t'(fetch_bypass_pkg::NUM_PORTS - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= sel_idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch_bypass_order_fifo.sv
// ***************************************************************************
// Fetch bypass order FIFO
// Records the owner of each refill in request order and routes each
// in-order refill response to that port
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fetch_bypass_order_fifo (
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  fetch_bypass_pkg::port_mask_t push_mask_i,
  input  logic                         refill_rsp_valid_i,

  output logic                         full_o,
  output logic                         refill_rsp_ready_o,
  output fetch_bypass_pkg::port_mask_t rsp_valid_o
);

  fetch_bypass_pkg::port_mask_t                         mem_q [fetch_bypass_pkg::ORDER_DEPTH];
  logic [$clog2(fetch_bypass_pkg::ORDER_DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(fetch_bypass_pkg::ORDER_DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(fetch_bypass_pkg::ORDER_DEPTH+1)-1:0]   count_q;
  logic                                                 push;
  logic                                                 pop;

  // Each granted request leaves a one-hot mask behind
  assign push = |push_mask_i;

  assign full_o             = (count_q == fetch_bypass_pkg::ORDER_DEPTH);
  assign refill_rsp_ready_o = (count_q != '0);
  assign pop                = refill_rsp_valid_i & refill_rsp_ready_o;

  // Responses return in request order, so the head names the owner
  assign rsp_valid_o = pop ? mem_q[rd_ptr_q] : '0;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == fetch_bypass_pkg::ORDER_DEPTH - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == fetch_bypass_pkg::ORDER_DEPTH - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch_bypass.sv
// ***************************************************************************
// Fetch bypass top level
// Uncached instruction fetch for several ports sharing one in-order
// line refill channel
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fetch_bypass (
  input  logic                                                        clk_i,
  input  logic                                                        reset_i,

  // Fetch side
  input  fetch_bypass_pkg::port_mask_t                                inst_valid_i,
  input  fetch_bypass_pkg::addr_t [fetch_bypass_pkg::NUM_PORTS-1:0]     inst_addr_i,
  output fetch_bypass_pkg::port_mask_t                                inst_ready_o,
  output fetch_bypass_pkg::fetch_data_t [fetch_bypass_pkg::NUM_PORTS-1:0] inst_data_o,
  output fetch_bypass_pkg::port_mask_t                                inst_error_o,

  // Refill request channel
  output logic                                                        refill_req_valid_o,
  input  logic                                                        refill_req_ready_i,
  output fetch_bypass_pkg::addr_t                                     refill_req_addr_o,

  // Refill response channel
  input  logic                                                        refill_rsp_valid_i,
  output logic                                                        refill_rsp_ready_o,
  input  fetch_bypass_pkg::line_data_t                                refill_rsp_data_i,
  input  logic                                                        refill_rsp_error_i
);

  fetch_bypass_pkg::port_mask_t                                 port_req;
  fetch_bypass_pkg::addr_t [fetch_bypass_pkg::NUM_PORTS-1:0]    port_req_addr;
  fetch_bypass_pkg::port_mask_t                                 port_grant;
  fetch_bypass_pkg::port_mask_t                                 port_rsp_valid;
  logic                                                         order_full;

  for (genvar i = 0; i < fetch_bypass_pkg::NUM_PORTS; i++) begin : gen_port
    fetch_bypass_port i_port (
      .clk_i        ( clk_i              ),
      .reset_i      ( reset_i            ),
      .inst_valid_i ( inst_valid_i[i]    ),
      .inst_addr_i  ( inst_addr_i[i]     ),
      .order_full_i ( order_full         ),
      .grant_i      ( port_grant[i]      ),
      .rsp_valid_i  ( port_rsp_valid[i]  ),
      .rsp_data_i   ( refill_rsp_data_i  ),
      .rsp_error_i  ( refill_rsp_error_i ),
      .req_o        ( port_req[i]        ),
      .req_addr_o   ( port_req_addr[i]   ),
      .inst_ready_o ( inst_ready_o[i]    ),
      .inst_data_o  ( inst_data_o[i]     ),
      .inst_error_o ( inst_error_o[i]    )
    );
  end

  // One line request at a time reaches the memory side
  fetch_bypass_arbiter i_arbiter (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .req_i              ( port_req           ),
    .req_addr_i         ( port_req_addr      ),
    .grant_o            ( port_grant         ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_req_addr_o  ( refill_req_addr_o  )
  );

  // The grant mask of every transfer doubles as the push data
  fetch_bypass_order_fifo i_order_fifo (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .push_mask_i        ( port_grant         ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .full_o             ( order_full         ),
    .refill_rsp_ready_o ( refill_rsp_ready_o ),
    .rsp_valid_o        ( port_rsp_valid     )
  );

endmodule

`default_nettype wire

//--- fetch_bypass_asserts.sv
// ***************************************************************************
// Fetch bypass protocol assertions
// Refill request stability, fetch ready pulses and the response
// handshake, bound onto the top level
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module fetch_bypass_asserts (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_valid_i,
  input  logic                         req_ready_i,
  input  fetch_bypass_pkg::addr_t      req_addr_i,
  input  fetch_bypass_pkg::port_mask_t inst_ready_i,
  input  logic                         rsp_valid_i,
  input  logic                         rsp_ready_i
);

  // A stalled refill request keeps both its valid and its address
  req_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_addr_i))
  ) else $error("refill request dropped or changed while stalled");

  // A port presents each word for one cycle only
  ready_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (inst_ready_i & $past(inst_ready_i)) == '0
  ) else $error("fetch ready held high for two cycles");

  // The memory side only answers requests that are still outstanding
  rsp_expected: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> rsp_ready_i
  ) else $error("refill response while no request is outstanding");

endmodule

`default_nettype wire

//--- tb_fetch_bypass.sv
// ***************************************************************************
// Fetch bypass testbench
// Random fetches on both ports against an in-order memory responder,
// with every returned word checked against a reference model
// ***************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_bypass;

  localparam int NP               = fetch_bypass_pkg::NUM_PORTS;
  localparam int FETCHES_PER_PORT = 300;
  localparam int TIMEOUT_CYCLES   = 20000;
  localparam fetch_bypass_pkg::addr_t LINE_MASK = (1 << fetch_bypass_pkg::LINE_ALIGN) - 1;
  localparam fetch_bypass_pkg::addr_t WORD_MASK = (1 << fetch_bypass_pkg::FETCH_ALIGN) - 1;
  localparam fetch_bypass_pkg::addr_t WORD_KEY  = 32'h5a3c_96e1;

  logic                                            clk_i;
  logic                                            reset_i;
  fetch_bypass_pkg::port_mask_t                    inst_valid_i;
  fetch_bypass_pkg::addr_t [NP-1:0]                inst_addr_i;
  fetch_bypass_pkg::port_mask_t                    inst_ready_o;
  fetch_bypass_pkg::fetch_data_t [NP-1:0]          inst_data_o;
  fetch_bypass_pkg::port_mask_t                    inst_error_o;
  logic                                            refill_req_valid_o;
  logic                                            refill_req_ready_i;
  fetch_bypass_pkg::addr_t                         refill_req_addr_o;
  logic                                            refill_rsp_valid_i;
  logic                                            refill_rsp_ready_o;
  fetch_bypass_pkg::line_data_t                    refill_rsp_data_i;
  logic                                            refill_rsp_error_i;

  // Reference model state
  fetch_bypass_pkg::addr_t       pend_addr [NP];
  logic [NP-1:0]                 pend_unreq;
  logic [NP-1:0]                 fetch_done;
  logic [NP-1:0]                 ready_prev;
  fetch_bypass_pkg::fetch_data_t exp_data_q [NP][$];
  logic                          exp_err_q [NP][$];
  int                            owner_q [$];
  fetch_bypass_pkg::addr_t       req_line_q [$];
  int                            due_q [$];
  int                            in_flight;
  int                            cycle_cnt;
  logic                          fetch_seen;
  logic                          rsp_taken;

  fetch_bypass dut0 (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .inst_valid_i       ( inst_valid_i       ),
    .inst_addr_i        ( inst_addr_i        ),
    .inst_ready_o       ( inst_ready_o       ),
    .inst_data_o        ( inst_data_o        ),
    .inst_error_o       ( inst_error_o       ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_ready_o ( refill_rsp_ready_o ),
    .refill_rsp_data_i  ( refill_rsp_data_i  ),
    .refill_rsp_error_i ( refill_rsp_error_i )
  );

  bind fetch_bypass fetch_bypass_asserts i_asserts (
    .clk_i        ( clk_i              ),
    .reset_i      ( reset_i            ),
    .req_valid_i  ( refill_req_valid_o ),
    .req_ready_i  ( refill_req_ready_i ),
    .req_addr_i   ( refill_req_addr_o  ),
    .inst_ready_i ( inst_ready_o       ),
    .rsp_valid_i  ( refill_rsp_valid_i ),
    .rsp_ready_i  ( refill_rsp_ready_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic fetch_bypass_pkg::addr_t line_of(input fetch_bypass_pkg::addr_t a);
    return a & ~LINE_MASK;
  endfunction

  // Every memory word holds its own address scrambled by a key
  function automatic fetch_bypass_pkg::line_data_t make_line(input fetch_bypass_pkg::addr_t a);
    fetch_bypass_pkg::line_data_t line;
    for (int k = 0; k < fetch_bypass_pkg::WORDS_PER_LINE; k++) begin
      line[k*fetch_bypass_pkg::FETCH_WIDTH +: fetch_bypass_pkg::FETCH_WIDTH] =
        (a + fetch_bypass_pkg::addr_t'(k << fetch_bypass_pkg::FETCH_ALIGN)) ^ WORD_KEY;
    end
    return line;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_fetch_data(input fetch_bypass_pkg::fetch_data_t got,
                                  input fetch_bypass_pkg::fetch_data_t exp,
                                  input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_refill_addr(input fetch_bypass_pkg::addr_t got,
                                   input fetch_bypass_pkg::addr_t exp,
                                   input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // A returned line goes to the oldest outstanding owner
  task automatic observe_response();
    int owner;
    if (refill_rsp_valid_i && refill_rsp_ready_o) begin
      if (owner_q.size() == 0) begin
        report_failure("refill response taken with no request outstanding");
      end
      owner = owner_q.pop_front();
      void'(req_line_q.pop_front());
      void'(due_q.pop_front());
      exp_data_q[owner].push_back(pend_addr[owner] ^ WORD_KEY);
      exp_err_q[owner].push_back(refill_rsp_error_i);
      in_flight--;
      rsp_taken = 1'b1;
    end
  endtask

  task automatic observe_request();
    int owner;
    if (refill_req_valid_o && refill_req_ready_i) begin
      owner = -1;
      for (int p = 0; p < NP; p++) begin
        if (owner < 0 && pend_unreq[p] && line_of(pend_addr[p]) == refill_req_addr_o) begin
          owner = p;
        end
      end
      // If nothing matches, pick any waiting port so the mismatch is shown
      for (int p = 0; p < NP; p++) begin
        if (owner < 0 && pend_unreq[p]) begin
          owner = p;
        end
      end
      if (owner < 0) begin
        report_failure("refill request while no fetch is waiting for one");
      end
      check_refill_addr(refill_req_addr_o, line_of(refill_req_addr_o), "refill alignment");
      check_refill_addr(refill_req_addr_o, line_of(pend_addr[owner]), "refill address");
      pend_unreq[owner] = 1'b0;
      owner_q.push_back(owner);
      req_line_q.push_back(refill_req_addr_o);
      due_q.push_back(cycle_cnt + $urandom_range(1, 8));
      in_flight++;
      if (in_flight > fetch_bypass_pkg::ORDER_DEPTH) begin
        report_failure("more refills in flight than the order FIFO can hold");
      end
    end
  endtask

  task automatic observe_fetches();
    fetch_bypass_pkg::fetch_data_t exp_data;
    logic                          exp_err;
    for (int p = 0; p < NP; p++) begin
      if (inst_ready_o[p]) begin
        if (ready_prev[p]) begin
          report_failure("fetch ready stayed high for two cycles");
        end
        if (exp_data_q[p].size() == 0 || !inst_valid_i[p]) begin
          report_failure("fetch ready without a pending fetch and its refill");
        end
        exp_data = exp_data_q[p].pop_front();
        exp_err  = exp_err_q[p].pop_front();
        check_fetch_data(inst_data_o[p], exp_data, "fetch word");
        check_error(inst_error_o[p], exp_err, "fetch error flag");
        fetch_done[p] = 1'b1;
      end
      ready_prev[p] = inst_ready_o[p];
    end
  endtask

  // Outputs are sampled mid-cycle, well away from the input drive time
  always @(negedge clk_i) begin
    if (!reset_i) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
        report_failure("timeout, not all fetches completed");
      end
      if (!fetch_seen && (inst_ready_o != '0 || refill_req_valid_o || refill_rsp_ready_o)) begin
        report_failure("handshake output high after reset before the first fetch");
      end
      if (inst_valid_i != '0) begin
        fetch_seen = 1'b1;
      end
      observe_response();
      observe_request();
      observe_fetches();
    end
  end

  task automatic drive_port(input int p);
    int gap;
    for (int n = 0; n < FETCHES_PER_PORT; n++) begin
      gap = $urandom_range(0, 4);
      repeat (gap) begin
        @(posedge clk_i);
        #2;
      end
      pend_addr[p]    = fetch_bypass_pkg::addr_t'($urandom()) & ~WORD_MASK;
      pend_unreq[p]   = 1'b1;
      inst_addr_i[p]  = pend_addr[p];
      inst_valid_i[p] = 1'b1;
      do begin
        @(posedge clk_i);
        #2;
      end while (!fetch_done[p]);
      fetch_done[p]   = 1'b0;
      inst_valid_i[p] = 1'b0;
    end
  endtask

  // In-order memory with a random request ready that answers each line once its delay is up
  task automatic respond();
    forever begin
      @(posedge clk_i);
      #2;
      refill_req_ready_i = ($urandom_range(0, 3) != 0);
      if (rsp_taken) begin
        refill_rsp_valid_i = 1'b0;
        rsp_taken          = 1'b0;
      end
      if (!refill_rsp_valid_i && req_line_q.size() != 0 && cycle_cnt >= due_q[0]) begin
        refill_rsp_valid_i = 1'b1;
        refill_rsp_data_i  = make_line(req_line_q[0]);
        refill_rsp_error_i = $urandom_range(0, 1);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h25c4_8c18));
    reset_i            = 1'b1;
    inst_valid_i       = '0;
    inst_addr_i        = '0;
    refill_req_ready_i = 1'b0;
    refill_rsp_valid_i = 1'b0;
    refill_rsp_data_i  = '0;
    refill_rsp_error_i = 1'b0;
    pend_unreq         = '0;
    fetch_done         = '0;
    ready_prev         = '0;
    in_flight          = 0;
    cycle_cnt          = 0;
    fetch_seen         = 1'b0;
    rsp_taken          = 1'b0;
    for (int p = 0; p < NP; p++) begin
      pend_addr[p] = '0;
    end
    repeat (10) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      #2;
    end
    fork
      respond();
    join_none
    fork
      drive_port(0);
      drive_port(1);
    join
    repeat (10) begin
      @(posedge clk_i);
      #2;
    end
    if (in_flight != 0 || owner_q.size() != 0) begin
      report_failure("refills still outstanding after the last fetch");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- list.f
fetch_bypass_pkg.sv
fetch_bypass_port.sv
fetch_bypass_arbiter.sv
fetch_bypass_order_fifo.sv
fetch_bypass.sv
fetch_bypass_asserts.sv
tb_fetch_bypass.sv

//--- Bender.yml
package:
  name: fetch_bypass

sources:
  - fetch_bypass_pkg.sv
  - fetch_bypass_port.sv
  - fetch_bypass_arbiter.sv
  - fetch_bypass_order_fifo.sv
  - fetch_bypass.sv
  - target: test
    files:
      - fetch_bypass_asserts.sv
      - tb_fetch_bypass.sv
